//--- design/udp_oe_csr_pkg.sv
// Shared definitions for the UDP offload engine CSR block
// Bus widths, word address map, feature header fields and reset defaults

package udp_oe_csr_pkg;

    // Bus and field widths
    localparam int CSR_DATA_W      = 64;
    localparam int CSR_ADDR_W      = 13;  // Byte address
    localparam int CSR_WORD_ADDR_W = 10;  // Byte address / 8
    localparam int MAC_W           = 48;
    localparam int IP_W            = 32;
    localparam int PORT_W          = 16;
    localparam int STATUS_W        = 32;  // One direction of a channel

    // Feature header words
    localparam logic [CSR_WORD_ADDR_W-1:0] DFH_HEADER_ADDR          = 10'd0;
    localparam logic [CSR_WORD_ADDR_W-1:0] DFH_ID_LO_ADDR           = 10'd1;
    localparam logic [CSR_WORD_ADDR_W-1:0] DFH_ID_HI_ADDR           = 10'd2;
    localparam logic [CSR_WORD_ADDR_W-1:0] DFH_REG_ADDR_OFFSET_ADDR = 10'd3;
    localparam logic [CSR_WORD_ADDR_W-1:0] DFH_REGSZ_PARAMS_ADDR    = 10'd4;

    localparam logic [CSR_WORD_ADDR_W-1:0] SCRATCHPAD_ADDR   = 10'd5;
    localparam logic [CSR_WORD_ADDR_W-1:0] NUM_CHANNELS_ADDR = 10'd6;

    // Network configuration, common to all channels
    localparam logic [CSR_WORD_ADDR_W-1:0] FPGA_MAC_ADDR           = 10'd8;
    localparam logic [CSR_WORD_ADDR_W-1:0] FPGA_IP_ADDR            = 10'd9;
    localparam logic [CSR_WORD_ADDR_W-1:0] FPGA_UDP_PORT_ADDR      = 10'd10;
    localparam logic [CSR_WORD_ADDR_W-1:0] FPGA_NETMASK_ADDR       = 10'd11;
    localparam logic [CSR_WORD_ADDR_W-1:0] HOST_MAC_ADDR           = 10'd12;
    localparam logic [CSR_WORD_ADDR_W-1:0] HOST_IP_ADDR            = 10'd13;
    localparam logic [CSR_WORD_ADDR_W-1:0] HOST_UDP_PORT_ADDR      = 10'd14;
    localparam logic [CSR_WORD_ADDR_W-1:0] PAYLOAD_PER_PACKET_ADDR = 10'd15;
    localparam logic [CSR_WORD_ADDR_W-1:0] CHECKSUM_IP_ADDR        = 10'd16;

    // Per-channel blocks start at word 0x20, eight words each
    localparam int CHAN_BASE_ADDR  = 32;
    localparam int CHAN_STRIDE     = 8;
    localparam int CHAN_INFO_OFS   = 0;
    localparam int CHAN_RESET_OFS  = 1;
    localparam int CHAN_STATUS_OFS = 2;
    localparam int CHAN_MISC_OFS   = 3;
    localparam int MAX_CHAN        = 16;

    // Feature header fields
    localparam logic [3:0]  DFH_FTYPE       = 4'h1;
    localparam logic [7:0]  DFH_VER         = 8'h01;
    localparam logic        DFH_EOL         = 1'b1;   // Last feature in the list
    localparam logic [23:0] DFH_NEXT        = 24'h0;
    localparam logic [3:0]  DFH_FEATURE_REV = 4'h0;
    localparam logic [11:0] DFH_FEATURE_ID  = 12'h021;

    localparam logic [CSR_DATA_W-1:0] DFH_HEADER_VALUE = {DFH_FTYPE, DFH_VER, 11'h0, DFH_EOL,
                                                          DFH_NEXT, DFH_FEATURE_REV,
                                                          DFH_FEATURE_ID};

    localparam logic [CSR_DATA_W-1:0] DFH_ID_LO = 64'hB174_9ECE_2A5B_4FD4;
    localparam logic [CSR_DATA_W-1:0] DFH_ID_HI = 64'h8C53_7D01_E6F3_A92E;

    // Registers start at the scratchpad, relative to the header
    localparam logic [CSR_DATA_W-1:0] DFH_REG_OFFSET_VALUE = 64'h0000_0000_0000_0028;
    // Size in bytes of the full map, no parameter block, group and instance 0
    localparam logic [CSR_DATA_W-1:0] DFH_REGSZ_VALUE =
        {32'((CHAN_BASE_ADDR + MAX_CHAN * CHAN_STRIDE) * 8), 1'b0, 15'h0, 16'h0};

    localparam logic [7:0]            CHAN_INFO_TAG              = 8'h10;
    localparam logic [PORT_W-1:0]     DEFAULT_PAYLOAD_PER_PACKET = 16'd1024;
    localparam logic [CSR_DATA_W-1:0] REG_RD_BADADDR_DATA        = 64'hBAAD_BEEF_DEAD_BEEF;

endpackage

//--- design/udp_oe_common_regs.sv
// Scratchpad and the nine shared network configuration registers
// Write decoding against the common part of the address map
`timescale 1ns/1ps

module udp_oe_common_regs (
    input  logic                                  uoe_csr_avmm,
    input  logic                                  rst_local,
    input  logic [udp_oe_csr_pkg::CSR_ADDR_W-1:0] address,
    input  logic                                  write,
    input  logic [udp_oe_csr_pkg::CSR_DATA_W-1:0] writedata,
    output logic [udp_oe_csr_pkg::CSR_DATA_W-1:0] scratchpad,
    output logic [udp_oe_csr_pkg::MAC_W-1:0]      fpga_mac_adr,
    output logic [udp_oe_csr_pkg::IP_W-1:0]       fpga_ip_adr,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]     fpga_udp_port,
    output logic [udp_oe_csr_pkg::IP_W-1:0]       fpga_netmask,
    output logic [udp_oe_csr_pkg::MAC_W-1:0]      host_mac_adr,
    output logic [udp_oe_csr_pkg::IP_W-1:0]       host_ip_adr,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]     host_udp_port,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]     payload_per_packet,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]     checksum_ip
);
    import udp_oe_csr_pkg::*;

    logic [CSR_WORD_ADDR_W-1:0] word_addr;

    // Accesses are whole 64-bit words
    assign word_addr = address[CSR_ADDR_W-1 -: CSR_WORD_ADDR_W];

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            scratchpad         <= '0;
            fpga_mac_adr       <= '0;
            fpga_ip_adr        <= '0;
            fpga_udp_port      <= '0;
            fpga_netmask       <= '0;
            host_mac_adr       <= '0;
            host_ip_adr        <= '0;
            host_udp_port      <= '0;
            payload_per_packet <= DEFAULT_PAYLOAD_PER_PACKET;
            checksum_ip        <= '0;
        end else if (write) begin
            case (word_addr)
                SCRATCHPAD_ADDR: begin
                    scratchpad <= writedata;  // Full word
                end
                FPGA_MAC_ADDR: begin
                    fpga_mac_adr <= writedata[MAC_W-1:0];
                end
                FPGA_IP_ADDR: begin
                    fpga_ip_adr <= writedata[IP_W-1:0];
                end
                FPGA_UDP_PORT_ADDR: begin
                    fpga_udp_port <= writedata[PORT_W-1:0];
                end
                FPGA_NETMASK_ADDR: begin
                    fpga_netmask <= writedata[IP_W-1:0];
                end
                HOST_MAC_ADDR: begin
                    host_mac_adr <= writedata[MAC_W-1:0];
                end
                HOST_IP_ADDR: begin
                    host_ip_adr <= writedata[IP_W-1:0];
                end
                HOST_UDP_PORT_ADDR: begin
                    host_udp_port <= writedata[PORT_W-1:0];
                end
                PAYLOAD_PER_PACKET_ADDR: begin
                    payload_per_packet <= writedata[PORT_W-1:0];  // Bytes per UDP packet
                end
                CHECKSUM_IP_ADDR: begin
                    checksum_ip <= writedata[PORT_W-1:0];
                end
                default: begin
                    // Read-only, channel or unmapped word, nothing stored here
                end
            endcase
        end
    end

endmodule

//--- design/udp_oe_chan_regs.sv
// Per-channel TX/RX reset registers and the shared misc control word
// One address match per channel, built by a generate loop
`timescale 1ns/1ps

module udp_oe_chan_regs #(
    parameter int NUM_CHAN = 4
) (
    input  logic                                  uoe_csr_avmm,
    input  logic                                  rst_local,
    input  logic [udp_oe_csr_pkg::CSR_ADDR_W-1:0] address,
    input  logic                                  write,
    input  logic [udp_oe_csr_pkg::CSR_DATA_W-1:0] writedata,
    output logic [udp_oe_csr_pkg::CSR_DATA_W-1:0] misc_ctrl,
    output logic [NUM_CHAN-1:0]                   tx_rst,
    output logic [NUM_CHAN-1:0]                   rx_rst
);
    import udp_oe_csr_pkg::*;

    logic [CSR_WORD_ADDR_W-1:0] word_addr;
    logic [NUM_CHAN-1:0]        rst_hit;   // Write to a channel's reset word
    logic [NUM_CHAN-1:0]        misc_hit;  // Write to a channel's misc word

    assign word_addr = address[CSR_ADDR_W-1 -: CSR_WORD_ADDR_W];

    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        localparam int BLK_BASE = CHAN_BASE_ADDR + c * CHAN_STRIDE;

        assign rst_hit[c]  = write &&
                             (word_addr == CSR_WORD_ADDR_W'(BLK_BASE + CHAN_RESET_OFS));
        assign misc_hit[c] = write &&
                             (word_addr == CSR_WORD_ADDR_W'(BLK_BASE + CHAN_MISC_OFS));
    end

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            tx_rst <= '0;
            rx_rst <= '0;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (rst_hit[i]) begin
                    tx_rst[i] <= writedata[1];
                    rx_rst[i] <= writedata[0];
                end
            end
        end
    end

    // Any channel's block can reach the single misc word
    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            misc_ctrl <= '0;
        end else if (|misc_hit) begin
            misc_ctrl <= writedata;
        end
    end

endmodule

//--- design/udp_oe_csr_read.sv
// Read address decode and read-data multiplexer
// Registered response, one cycle after the sampled read
`timescale 1ns/1ps

module udp_oe_csr_read #(
    parameter int NUM_CHAN = 4
) (
    input  logic                                           uoe_csr_avmm,
    input  logic                                           rst_local,
    input  logic [udp_oe_csr_pkg::CSR_ADDR_W-1:0]          address,
    input  logic                                           read,
    input  logic [udp_oe_csr_pkg::CSR_DATA_W-1:0]          scratchpad,
    input  logic [udp_oe_csr_pkg::MAC_W-1:0]               fpga_mac_adr,
    input  logic [udp_oe_csr_pkg::IP_W-1:0]                fpga_ip_adr,
    input  logic [udp_oe_csr_pkg::PORT_W-1:0]              fpga_udp_port,
    input  logic [udp_oe_csr_pkg::IP_W-1:0]                fpga_netmask,
    input  logic [udp_oe_csr_pkg::MAC_W-1:0]               host_mac_adr,
    input  logic [udp_oe_csr_pkg::IP_W-1:0]                host_ip_adr,
    input  logic [udp_oe_csr_pkg::PORT_W-1:0]              host_udp_port,
    input  logic [udp_oe_csr_pkg::PORT_W-1:0]              payload_per_packet,
    input  logic [udp_oe_csr_pkg::PORT_W-1:0]              checksum_ip,
    input  logic [udp_oe_csr_pkg::CSR_DATA_W-1:0]          misc_ctrl,
    input  logic [NUM_CHAN-1:0]                            tx_rst,
    input  logic [NUM_CHAN-1:0]                            rx_rst,
    input  logic [NUM_CHAN*udp_oe_csr_pkg::STATUS_W-1:0]   tx_status,
    input  logic [NUM_CHAN*udp_oe_csr_pkg::STATUS_W-1:0]   rx_status,
    output logic [udp_oe_csr_pkg::CSR_DATA_W-1:0]          readdata,
    output logic                                           readdatavalid
);
    import udp_oe_csr_pkg::*;

    localparam int OFS_W = $clog2(CHAN_STRIDE);
    localparam int IDX_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

    localparam logic [CSR_WORD_ADDR_W-1:0] CHAN_LO = CSR_WORD_ADDR_W'(CHAN_BASE_ADDR);
    localparam logic [CSR_WORD_ADDR_W-1:0] CHAN_HI =
        CSR_WORD_ADDR_W'(CHAN_BASE_ADDR + NUM_CHAN * CHAN_STRIDE);  // First word past the blocks

    logic [CSR_WORD_ADDR_W-1:0] word_addr;
    logic [CSR_WORD_ADDR_W-1:0] chan_rel;
    logic                       chan_hit;
    logic [IDX_W-1:0]           chan_idx;
    logic [OFS_W-1:0]           chan_ofs;
    logic [CSR_DATA_W-1:0]      rd_mux;

    assign word_addr = address[CSR_ADDR_W-1 -: CSR_WORD_ADDR_W];

    // Split a channel-block address into channel index and offset
    assign chan_hit = (word_addr >= CHAN_LO) && (word_addr < CHAN_HI);
    assign chan_rel = word_addr - CHAN_LO;
    assign chan_idx = chan_rel[OFS_W +: IDX_W];
    assign chan_ofs = chan_rel[OFS_W-1:0];

    always_comb begin
        rd_mux = REG_RD_BADADDR_DATA;
        case (word_addr)
            DFH_HEADER_ADDR:          rd_mux = DFH_HEADER_VALUE;
            DFH_ID_LO_ADDR:           rd_mux = DFH_ID_LO;
            DFH_ID_HI_ADDR:           rd_mux = DFH_ID_HI;
            DFH_REG_ADDR_OFFSET_ADDR: rd_mux = DFH_REG_OFFSET_VALUE;
            DFH_REGSZ_PARAMS_ADDR:    rd_mux = DFH_REGSZ_VALUE;
            SCRATCHPAD_ADDR:          rd_mux = scratchpad;
            NUM_CHANNELS_ADDR:        rd_mux = CSR_DATA_W'(NUM_CHAN);
            FPGA_MAC_ADDR:            rd_mux = CSR_DATA_W'(fpga_mac_adr);
            FPGA_IP_ADDR:             rd_mux = CSR_DATA_W'(fpga_ip_adr);
            FPGA_UDP_PORT_ADDR:       rd_mux = CSR_DATA_W'(fpga_udp_port);
            FPGA_NETMASK_ADDR:        rd_mux = CSR_DATA_W'(fpga_netmask);
            HOST_MAC_ADDR:            rd_mux = CSR_DATA_W'(host_mac_adr);
            HOST_IP_ADDR:             rd_mux = CSR_DATA_W'(host_ip_adr);
            HOST_UDP_PORT_ADDR:       rd_mux = CSR_DATA_W'(host_udp_port);
            PAYLOAD_PER_PACKET_ADDR:  rd_mux = CSR_DATA_W'(payload_per_packet);
            CHECKSUM_IP_ADDR:         rd_mux = CSR_DATA_W'(checksum_ip);
            default: begin
                if (chan_hit) begin
                    case (chan_ofs)
                        OFS_W'(CHAN_INFO_OFS):
                            rd_mux = {48'h0, 8'(chan_idx), CHAN_INFO_TAG};
                        OFS_W'(CHAN_RESET_OFS):
                            rd_mux = {62'h0, tx_rst[chan_idx], rx_rst[chan_idx]};
                        OFS_W'(CHAN_STATUS_OFS):
                            rd_mux = {tx_status[chan_idx*STATUS_W +: STATUS_W],
                                      rx_status[chan_idx*STATUS_W +: STATUS_W]};
                        OFS_W'(CHAN_MISC_OFS):
                            rd_mux = misc_ctrl;
                        default:
                            rd_mux = '0;  // Spare slots of the block
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            readdata      <= '0;
            readdatavalid <= 1'b0;
        end else begin
            readdatavalid <= read;       // Fixed one-cycle latency
            if (read) begin
                readdata <= rd_mux;      // Held until the next read
            end
        end
    end

endmodule

//--- design/udp_oe_csr.sv
// Top level of the UDP offload engine CSR block
// Common registers, channel registers and read path
`timescale 1ns/1ps

module udp_oe_csr #(
    parameter int NUM_CHAN = 4
) (
    input  logic                                         uoe_csr_avmm,
    input  logic                                         rst_local,
    input  logic [udp_oe_csr_pkg::CSR_ADDR_W-1:0]        address,
    input  logic                                         read,
    input  logic                                         write,
    input  logic [udp_oe_csr_pkg::CSR_DATA_W-1:0]        writedata,
    input  logic [NUM_CHAN*udp_oe_csr_pkg::STATUS_W-1:0] tx_status,
    input  logic [NUM_CHAN*udp_oe_csr_pkg::STATUS_W-1:0] rx_status,
    output logic [udp_oe_csr_pkg::CSR_DATA_W-1:0]        readdata,
    output logic                                         readdatavalid,
    output logic [udp_oe_csr_pkg::MAC_W-1:0]             fpga_mac_adr,
    output logic [udp_oe_csr_pkg::IP_W-1:0]              fpga_ip_adr,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]            fpga_udp_port,
    output logic [udp_oe_csr_pkg::IP_W-1:0]              fpga_netmask,
    output logic [udp_oe_csr_pkg::MAC_W-1:0]             host_mac_adr,
    output logic [udp_oe_csr_pkg::IP_W-1:0]              host_ip_adr,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]            host_udp_port,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]            payload_per_packet,
    output logic [udp_oe_csr_pkg::PORT_W-1:0]            checksum_ip,
    output logic [udp_oe_csr_pkg::CSR_DATA_W-1:0]        misc_ctrl,
    output logic [NUM_CHAN-1:0]                          tx_rst,
    output logic [NUM_CHAN-1:0]                          rx_rst
);
    import udp_oe_csr_pkg::*;

    logic [CSR_DATA_W-1:0] scratchpad;  // Only visible through reads

    udp_oe_common_regs i_common_regs (
        .uoe_csr_avmm       (uoe_csr_avmm),
        .rst_local          (rst_local),
        .address            (address),
        .write              (write),
        .writedata          (writedata),
        .scratchpad         (scratchpad),
        .fpga_mac_adr       (fpga_mac_adr),
        .fpga_ip_adr        (fpga_ip_adr),
        .fpga_udp_port      (fpga_udp_port),
        .fpga_netmask       (fpga_netmask),
        .host_mac_adr       (host_mac_adr),
        .host_ip_adr        (host_ip_adr),
        .host_udp_port      (host_udp_port),
        .payload_per_packet (payload_per_packet),
        .checksum_ip        (checksum_ip)
    );

    udp_oe_chan_regs #(
        .NUM_CHAN (NUM_CHAN)
    ) i_chan_regs (
        .uoe_csr_avmm (uoe_csr_avmm),
        .rst_local    (rst_local),
        .address      (address),
        .write        (write),
        .writedata    (writedata),
        .misc_ctrl    (misc_ctrl),
        .tx_rst       (tx_rst),
        .rx_rst       (rx_rst)
    );

    // Read path sees the register outputs directly
    udp_oe_csr_read #(
        .NUM_CHAN (NUM_CHAN)
    ) i_csr_read (
        .uoe_csr_avmm       (uoe_csr_avmm),
        .rst_local          (rst_local),
        .address            (address),
        .read               (read),
        .scratchpad         (scratchpad),
        .fpga_mac_adr       (fpga_mac_adr),
        .fpga_ip_adr        (fpga_ip_adr),
        .fpga_udp_port      (fpga_udp_port),
        .fpga_netmask       (fpga_netmask),
        .host_mac_adr       (host_mac_adr),
        .host_ip_adr        (host_ip_adr),
        .host_udp_port      (host_udp_port),
        .payload_per_packet (payload_per_packet),
        .checksum_ip        (checksum_ip),
        .misc_ctrl          (misc_ctrl),
        .tx_rst             (tx_rst),
        .rx_rst             (rx_rst),
        .tx_status          (tx_status),
        .rx_status          (rx_status),
        .readdata           (readdata),
        .readdatavalid      (readdatavalid)
    );

endmodule

//--- test/udp_oe_csr_props.sv
// Concurrent checks on the CSR block
// Reset state of all registers and the one-cycle read response
`timescale 1ns/1ps

module udp_oe_csr_props #(
    parameter int NUM_CHAN = 4
) (
    input logic                                  uoe_csr_avmm,
    input logic                                  rst_local,
    input logic                                  read,
    input logic [udp_oe_csr_pkg::CSR_DATA_W-1:0] readdata,
    input logic                                  readdatavalid,
    input logic [udp_oe_csr_pkg::MAC_W-1:0]      fpga_mac_adr,
    input logic [udp_oe_csr_pkg::IP_W-1:0]       fpga_ip_adr,
    input logic [udp_oe_csr_pkg::PORT_W-1:0]     fpga_udp_port,
    input logic [udp_oe_csr_pkg::IP_W-1:0]       fpga_netmask,
    input logic [udp_oe_csr_pkg::MAC_W-1:0]      host_mac_adr,
    input logic [udp_oe_csr_pkg::IP_W-1:0]       host_ip_adr,
    input logic [udp_oe_csr_pkg::PORT_W-1:0]     host_udp_port,
    input logic [udp_oe_csr_pkg::PORT_W-1:0]     payload_per_packet,
    input logic [udp_oe_csr_pkg::PORT_W-1:0]     checksum_ip,
    input logic [udp_oe_csr_pkg::CSR_DATA_W-1:0] misc_ctrl,
    input logic [NUM_CHAN-1:0]                   tx_rst,
    input logic [NUM_CHAN-1:0]                   rx_rst
);

    // Network config at defaults, payload size is the only nonzero one
    a_reset_config: assert property (@(posedge uoe_csr_avmm) rst_local |=>
        (fpga_mac_adr == '0 && fpga_ip_adr == '0 && fpga_udp_port == '0 &&
         fpga_netmask == '0 && host_mac_adr == '0 && host_ip_adr == '0 &&
         host_udp_port == '0 && checksum_ip == '0 && payload_per_packet == 16'd1024))
        else $error("network configuration not at its default after reset");

    a_reset_chan: assert property (@(posedge uoe_csr_avmm) rst_local |=>
        (misc_ctrl == '0 && tx_rst == '0 && rx_rst == '0 && !readdatavalid && readdata == '0))
        else $error("channel registers or read response not clear after reset");

    a_valid_after_read: assert property (@(posedge uoe_csr_avmm)
        (!rst_local && read) |=> readdatavalid)
        else $error("readdatavalid missing one cycle after a read");

    a_valid_only_after_read: assert property (@(posedge uoe_csr_avmm)
        (rst_local || !read) |=> !readdatavalid)
        else $error("readdatavalid high without a read in the cycle before");

endmodule

//--- test/tb_udp_oe_csr.sv
// Testbench for the UDP offload engine CSR block
// Bus write and read tasks, register map stimulus and immediate checks
`timescale 1ns/1ps

module tb_udp_oe_csr;
    import udp_oe_csr_pkg::*;

    localparam int NUM_CHAN       = 4;
    localparam int TIMEOUT_CYCLES = 20;

    logic                         uoe_csr_avmm = 1'b0;
    logic                         rst_local;
    logic [CSR_ADDR_W-1:0]        address;
    logic                         read;
    logic                         write;
    logic [CSR_DATA_W-1:0]        writedata;
    logic [NUM_CHAN*STATUS_W-1:0] tx_status;
    logic [NUM_CHAN*STATUS_W-1:0] rx_status;
    logic [CSR_DATA_W-1:0]        readdata;
    logic                         readdatavalid;
    logic [MAC_W-1:0]             fpga_mac_adr;
    logic [IP_W-1:0]              fpga_ip_adr;
    logic [PORT_W-1:0]            fpga_udp_port;
    logic [IP_W-1:0]              fpga_netmask;
    logic [MAC_W-1:0]             host_mac_adr;
    logic [IP_W-1:0]              host_ip_adr;
    logic [PORT_W-1:0]            host_udp_port;
    logic [PORT_W-1:0]            payload_per_packet;
    logic [PORT_W-1:0]            checksum_ip;
    logic [CSR_DATA_W-1:0]        misc_ctrl;
    logic [NUM_CHAN-1:0]          tx_rst;
    logic [NUM_CHAN-1:0]          rx_rst;

    integer                seed;
    int                    base;
    logic [CSR_DATA_W-1:0] wr_data;
    logic [CSR_DATA_W-1:0] rd_data;
    logic [CSR_DATA_W-1:0] exp_data;
    logic [NUM_CHAN-1:0]   exp_tx_rst;
    logic [NUM_CHAN-1:0]   exp_rx_rst;

    // Scratchpad and the nine network words with their stored widths
    int net_word [10]  = '{5, 8, 9, 10, 11, 12, 13, 14, 15, 16};
    int net_width [10] = '{64, 48, 32, 16, 32, 48, 32, 16, 16, 16};
    // Header words and channel count
    int ro_word [6] = '{0, 1, 2, 3, 4, 6};
    logic [CSR_DATA_W-1:0] ro_value [6] = '{DFH_HEADER_VALUE, DFH_ID_LO, DFH_ID_HI,
                                            DFH_REG_OFFSET_VALUE, DFH_REGSZ_VALUE, 64'd4};
    int unmapped_word [6] = '{7, 17, 31, 64, 100, 1023};

    always #2 uoe_csr_avmm = ~uoe_csr_avmm;  // 4 ns period

    udp_oe_csr #(
        .NUM_CHAN (NUM_CHAN)
    ) i_udp_oe_csr (
        .uoe_csr_avmm       (uoe_csr_avmm),
        .rst_local          (rst_local),
        .address            (address),
        .read               (read),
        .write              (write),
        .writedata          (writedata),
        .tx_status          (tx_status),
        .rx_status          (rx_status),
        .readdata           (readdata),
        .readdatavalid      (readdatavalid),
        .fpga_mac_adr       (fpga_mac_adr),
        .fpga_ip_adr        (fpga_ip_adr),
        .fpga_udp_port      (fpga_udp_port),
        .fpga_netmask       (fpga_netmask),
        .host_mac_adr       (host_mac_adr),
        .host_ip_adr        (host_ip_adr),
        .host_udp_port      (host_udp_port),
        .payload_per_packet (payload_per_packet),
        .checksum_ip        (checksum_ip),
        .misc_ctrl          (misc_ctrl),
        .tx_rst             (tx_rst),
        .rx_rst             (rx_rst)
    );

    bind udp_oe_csr udp_oe_csr_props #(.NUM_CHAN(NUM_CHAN)) i_props (
        .uoe_csr_avmm       (uoe_csr_avmm),
        .rst_local          (rst_local),
        .read               (read),
        .readdata           (readdata),
        .readdatavalid      (readdatavalid),
        .fpga_mac_adr       (fpga_mac_adr),
        .fpga_ip_adr        (fpga_ip_adr),
        .fpga_udp_port      (fpga_udp_port),
        .fpga_netmask       (fpga_netmask),
        .host_mac_adr       (host_mac_adr),
        .host_ip_adr        (host_ip_adr),
        .host_udp_port      (host_udp_port),
        .payload_per_packet (payload_per_packet),
        .checksum_ip        (checksum_ip),
        .misc_ctrl          (misc_ctrl),
        .tx_rst             (tx_rst),
        .rx_rst             (rx_rst)
    );

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    // Output port that mirrors a network register by table index
    function automatic logic [63:0] config_port(input int idx);
        case (idx)
            1: return 64'(fpga_mac_adr);
            2: return 64'(fpga_ip_adr);
            3: return 64'(fpga_udp_port);
            4: return 64'(fpga_netmask);
            5: return 64'(host_mac_adr);
            6: return 64'(host_ip_adr);
            7: return 64'(host_udp_port);
            8: return 64'(payload_per_packet);
            9: return 64'(checksum_ip);
            default: return '0;
        endcase
    endfunction

    // Starts just after a rising edge and returns just after the sampling edge
    task automatic write_word(input int word, input logic [63:0] data);
        address   <= CSR_ADDR_W'(word * 8);
        writedata <= data;
        write     <= 1'b1;
        @(posedge uoe_csr_avmm);
        write <= 1'b0;
    endtask

    task automatic read_word(input int word, output logic [63:0] data);
        int waited;
        address <= CSR_ADDR_W'(word * 8);
        read    <= 1'b1;
        @(posedge uoe_csr_avmm);
        read   <= 1'b0;
        waited = 0;
        @(negedge uoe_csr_avmm);
        while (!readdatavalid) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Read of word %0d got no readdatavalid in %0d cycles", word, waited);
                $display("TEST RESULT: FAIL");
                $fatal(1, "read timeout");
            end
            @(negedge uoe_csr_avmm);
        end
        data = readdata;
        @(posedge uoe_csr_avmm);  // Back in step with the drive edge
    endtask

    initial begin
        seed       = 32'h2c7a44cb;
        rst_local  = 1'b1;
        address    = '0;
        read       = 1'b0;
        write      = 1'b0;
        writedata  = '0;
        tx_status  = '0;
        rx_status  = '0;
        exp_tx_rst = '0;
        exp_rx_rst = '0;
        repeat (2) @(posedge uoe_csr_avmm);
        rst_local <= 1'b0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            tx_status[c*STATUS_W +: STATUS_W] <= $random(seed);
            rx_status[c*STATUS_W +: STATUS_W] <= $random(seed);
        end
        @(posedge uoe_csr_avmm);

        read_word(15, rd_data);
        check_value("payload default", 64'd1024, rd_data);

        // Scratchpad and network registers read right after the write
        for (int i = 0; i < 10; i++) begin
            wr_data  = random_word();
            exp_data = (net_width[i] == 64) ? wr_data :
                       wr_data & ((64'd1 << net_width[i]) - 64'd1);
            write_word(net_word[i], wr_data);
            read_word(net_word[i], rd_data);
            check_value($sformatf("readback word %0d", net_word[i]), exp_data, rd_data);
            if (i > 0) begin
                check_value($sformatf("port of word %0d", net_word[i]), exp_data,
                            config_port(i));
            end
        end

        // Read-only words before and after writes to them
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 6; k++) begin
                read_word(ro_word[k], rd_data);
                check_value($sformatf("read-only word %0d round %0d", ro_word[k], round),
                            ro_value[k], rd_data);
            end
            if (round == 0) begin
                for (int k = 0; k < 6; k++) begin
                    write_word(ro_word[k], random_word());
                end
            end
        end

        for (int c = 0; c < NUM_CHAN; c++) begin
            base          = CHAN_BASE_ADDR + c * CHAN_STRIDE;
            wr_data       = random_word();
            exp_tx_rst[c] = wr_data[1];
            exp_rx_rst[c] = wr_data[0];
            write_word(base + CHAN_RESET_OFS, wr_data);
            read_word(base + CHAN_RESET_OFS, rd_data);
            check_value($sformatf("chan %0d reset word", c), {62'h0, wr_data[1:0]}, rd_data);
            check_value($sformatf("chan %0d tx_rst", c), 64'(exp_tx_rst), 64'(tx_rst));
            check_value($sformatf("chan %0d rx_rst", c), 64'(exp_rx_rst), 64'(rx_rst));
            read_word(base + CHAN_INFO_OFS, rd_data);
            check_value($sformatf("chan %0d info", c), 64'((c << 8) + 'h10), rd_data);
            read_word(base + CHAN_STATUS_OFS, rd_data);
            check_value($sformatf("chan %0d status", c),
                        {tx_status[c*STATUS_W +: STATUS_W], rx_status[c*STATUS_W +: STATUS_W]},
                        rd_data);
            for (int ofs = 4; ofs < 8; ofs++) begin
                read_word(base + ofs, rd_data);
                check_value($sformatf("chan %0d spare offset %0d", c, ofs), 64'h0, rd_data);
            end
        end

        // One misc word behind every channel block
        wr_data = random_word();
        write_word(CHAN_BASE_ADDR + 2 * CHAN_STRIDE + CHAN_MISC_OFS, wr_data);
        for (int c = 0; c < NUM_CHAN; c++) begin
            read_word(CHAN_BASE_ADDR + c * CHAN_STRIDE + CHAN_MISC_OFS, rd_data);
            check_value($sformatf("misc through chan %0d", c), wr_data, rd_data);
        end
        check_value("misc_ctrl port", wr_data, misc_ctrl);

        for (int k = 0; k < 6; k++) begin
            read_word(unmapped_word[k], rd_data);
            check_value($sformatf("unmapped word %0d", unmapped_word[k]),
                        64'hBAAD_BEEF_DEAD_BEEF, rd_data);
        end

        // Second reset while the registers hold written values
        rst_local <= 1'b1;
        repeat (2) @(posedge uoe_csr_avmm);
        rst_local <= 1'b0;
        @(posedge uoe_csr_avmm);
        read_word(15, rd_data);
        check_value("payload default after reset", 64'd1024, rd_data);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- udp_oe_csr.f
design/udp_oe_csr_pkg.sv
design/udp_oe_common_regs.sv
design/udp_oe_chan_regs.sv
design/udp_oe_csr_read.sv
design/udp_oe_csr.sv
test/udp_oe_csr_props.sv
test/tb_udp_oe_csr.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert -Wno-fatal --top-module tb_udp_oe_csr -f udp_oe_csr.f \
    -o tb_udp_oe_csr > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_udp_oe_csr > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
